// ==== design/rv64_id_config.svh ====
`ifndef RV64_ID_CONFIG_SVH
`define RV64_ID_CONFIG_SVH

// datapath widths
`define RV_XLEN        64 // data and address width
`define RV_INST_W      32 // instruction width

// register file geometry
`define RV_REG_AW      5  // register address width
`define RV_NUM_REGS    32

// immediate shift amount, 6 bits on rv64
`define RV_SHAMT_W     6

// return address is pc + 4
`define RV_LINK_OFFSET 4

`endif

// ==== design/rv64_id_pkg.sv ====
package rv64_id_pkg;

    // major opcodes kept by the decoder, inst[6:0]
    typedef enum logic [6:0] {
        LOAD      = 7'b0000011,
        OP_IMM    = 7'b0010011,
        AUIPC     = 7'b0010111,
        OP_IMM_32 = 7'b0011011,
        STORE     = 7'b0100011,
        OP        = 7'b0110011,
        LUI       = 7'b0110111,
        OP_32     = 7'b0111011,
        BRANCH    = 7'b1100011,
        JALR      = 7'b1100111,
        JAL       = 7'b1101111
    } opcode_e;

    // op1 source
    typedef enum logic [1:0] {
        OP1_ZERO,
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    // op2 source
    typedef enum logic [2:0] {
        OP2_ZERO,
        OP2_RS2,
        OP2_RS2_SHAMT, // rs2 masked to low 6 bits
        OP2_IMM_I,
        OP2_IMM_U,
        OP2_SHAMT,     // shamt field of the instruction
        OP2_LINK
    } op2_sel_e;

    // branch / memory base
    typedef enum logic [1:0] {
        BASE_ZERO,
        BASE_PC,
        BASE_RS1
    } base_sel_e;

    // branch / memory offset
    typedef enum logic [2:0] {
        OFF_ZERO,
        OFF_IMM_I,
        OFF_IMM_S,
        OFF_IMM_B,
        OFF_IMM_J,
        OFF_IMM_U
    } offset_sel_e;

endpackage

// ==== design/decode_if.sv ====
`include "rv64_id_config.svh"

// decoder selects towards the operand mux
interface decode_ctrl_if;
    rv64_id_pkg::op1_sel_e    op1_sel;
    rv64_id_pkg::op2_sel_e    op2_sel;
    rv64_id_pkg::base_sel_e   base_sel;
    rv64_id_pkg::offset_sel_e offset_sel;
    logic                     reg_wen;

    modport source (output op1_sel, op2_sel, base_sel, offset_sel, reg_wen);
    modport sink   (input  op1_sel, op2_sel, base_sel, offset_sel, reg_wen);
endinterface

// execute bundle before the pipeline register
interface id_ex_if;
    logic                  valid;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic [`RV_XLEN-1:0]   base;
    logic [`RV_XLEN-1:0]   offset;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic                  reg_wen;
    logic [`RV_INST_W-1:0] inst;
    logic [`RV_XLEN-1:0]   inst_addr;

    modport source (output valid, op1, op2, base, offset, rd_addr, reg_wen,
                    inst, inst_addr);
    modport sink   (input  valid, op1, op2, base, offset, rd_addr, reg_wen,
                    inst, inst_addr);
endinterface

// ==== design/reg_file.sv ====
`include "rv64_id_config.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [`RV_REG_AW-1:0] rs1_addr_i,
    input  logic [`RV_REG_AW-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o,
    input  logic                  wen_i,
    input  logic [`RV_REG_AW-1:0] waddr_i,
    input  logic [`RV_XLEN-1:0]   wdata_i
);

    logic [`RV_XLEN-1:0] regs [0:`RV_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass, a same-edge write shows up next cycle
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== design/inst_decoder.sv ====
`include "rv64_id_config.svh"

module inst_decoder (
    input  logic [`RV_INST_W-1:0] inst_i,
    output logic [`RV_REG_AW-1:0] rs1_addr_o,
    output logic [`RV_REG_AW-1:0] rs2_addr_o,
    output logic [`RV_REG_AW-1:0] rd_addr_o,
    decode_ctrl_if.source         ctrl
);

    localparam logic [6:0] F7_BASE   = 7'b0000000; // srl
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // m extension

    rv64_id_pkg::opcode_e opcode;
    logic [2:0]           func3;
    logic [6:0]           func7;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 wen;

    assign opcode = rv64_id_pkg::opcode_e'(inst_i[6:0]);
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];

    always_comb begin
        // anything not matched below stays all zero
        use_rs1         = 1'b0;
        use_rs2         = 1'b0;
        wen             = 1'b0;
        ctrl.op1_sel    = rv64_id_pkg::OP1_ZERO;
        ctrl.op2_sel    = rv64_id_pkg::OP2_ZERO;
        ctrl.base_sel   = rv64_id_pkg::BASE_ZERO;
        ctrl.offset_sel = rv64_id_pkg::OFF_ZERO;
        case (opcode)
            rv64_id_pkg::OP_IMM, rv64_id_pkg::OP_IMM_32: begin
                // word form only has addiw, slliw, sr*iw
                if (opcode == rv64_id_pkg::OP_IMM || func3 inside {3'b000, 3'b001, 3'b101}) begin
                    use_rs1      = 1'b1;
                    wen          = 1'b1;
                    ctrl.op1_sel = rv64_id_pkg::OP1_RS1;
                    if (func3 == 3'b001 || func3 == 3'b101) begin
                        ctrl.op2_sel = rv64_id_pkg::OP2_SHAMT;
                    end else begin
                        ctrl.op2_sel = rv64_id_pkg::OP2_IMM_I;
                    end
                end
            end
            rv64_id_pkg::OP: begin
                if (func3 != 3'b101 || func7 inside {F7_BASE, F7_ALT, F7_MULDIV}) begin
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    wen          = 1'b1;
                    ctrl.op1_sel = rv64_id_pkg::OP1_RS1;
                    // sll, srl, sra take only the low 6 bits of rs2
                    if (func3 == 3'b001 || (func3 == 3'b101 && func7 != F7_MULDIV)) begin
                        ctrl.op2_sel = rv64_id_pkg::OP2_RS2_SHAMT;
                    end else begin
                        ctrl.op2_sel = rv64_id_pkg::OP2_RS2; // divu and the rest
                    end
                end
            end
            rv64_id_pkg::OP_32: begin
                if (!(func3 inside {3'b010, 3'b011})) begin
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    wen          = 1'b1;
                    ctrl.op1_sel = rv64_id_pkg::OP1_RS1;
                    ctrl.op2_sel = rv64_id_pkg::OP2_RS2;
                end
            end
            rv64_id_pkg::BRANCH: begin
                if (!(func3 inside {3'b010, 3'b011})) begin
                    use_rs1         = 1'b1;
                    use_rs2         = 1'b1;
                    ctrl.op1_sel    = rv64_id_pkg::OP1_RS1;
                    ctrl.op2_sel    = rv64_id_pkg::OP2_RS2;
                    ctrl.base_sel   = rv64_id_pkg::BASE_PC;
                    ctrl.offset_sel = rv64_id_pkg::OFF_IMM_B;
                end
            end
            rv64_id_pkg::LOAD: begin
                if (func3 != 3'b111) begin
                    use_rs1         = 1'b1;
                    wen             = 1'b1;
                    ctrl.op1_sel    = rv64_id_pkg::OP1_RS1;
                    ctrl.op2_sel    = rv64_id_pkg::OP2_IMM_I;
                    ctrl.base_sel   = rv64_id_pkg::BASE_RS1;
                    ctrl.offset_sel = rv64_id_pkg::OFF_IMM_I;
                end
            end
            rv64_id_pkg::STORE: begin
                if (!func3[2]) begin // sb, sh, sw, sd
                    use_rs1         = 1'b1;
                    use_rs2         = 1'b1;
                    ctrl.op2_sel    = rv64_id_pkg::OP2_RS2; // store data
                    ctrl.base_sel   = rv64_id_pkg::BASE_RS1;
                    ctrl.offset_sel = rv64_id_pkg::OFF_IMM_S;
                end
            end
            rv64_id_pkg::JAL: begin
                wen             = 1'b1;
                ctrl.op1_sel    = rv64_id_pkg::OP1_PC;
                ctrl.op2_sel    = rv64_id_pkg::OP2_LINK;
                ctrl.base_sel   = rv64_id_pkg::BASE_PC;
                ctrl.offset_sel = rv64_id_pkg::OFF_IMM_J;
            end
            rv64_id_pkg::JALR: begin
                use_rs1         = 1'b1;
                wen             = 1'b1;
                ctrl.op1_sel    = rv64_id_pkg::OP1_PC;
                ctrl.op2_sel    = rv64_id_pkg::OP2_LINK;
                ctrl.base_sel   = rv64_id_pkg::BASE_RS1;
                ctrl.offset_sel = rv64_id_pkg::OFF_IMM_I;
            end
            rv64_id_pkg::LUI: begin
                wen          = 1'b1;
                ctrl.op2_sel = rv64_id_pkg::OP2_IMM_U;
            end
            rv64_id_pkg::AUIPC: begin
                wen             = 1'b1;
                ctrl.op1_sel    = rv64_id_pkg::OP1_PC;
                ctrl.op2_sel    = rv64_id_pkg::OP2_IMM_U;
                ctrl.offset_sel = rv64_id_pkg::OFF_IMM_U;
            end
            default: begin
            end
        endcase
    end

    // unused fields read as register zero
    assign rs1_addr_o   = use_rs1 ? inst_i[19:15] : '0;
    assign rs2_addr_o   = use_rs2 ? inst_i[24:20] : '0;
    assign rd_addr_o    = wen ? inst_i[11:7] : '0;
    assign ctrl.reg_wen = wen;

endmodule

// ==== design/operand_mux.sv ====
`include "rv64_id_config.svh"

module operand_mux (
    input  logic                  inst_valid_i,
    input  logic [`RV_INST_W-1:0] inst_i,
    input  logic [`RV_XLEN-1:0]   inst_addr_i,
    input  logic [`RV_XLEN-1:0]   rs1_data_i,
    input  logic [`RV_XLEN-1:0]   rs2_data_i,
    input  logic [`RV_REG_AW-1:0] rd_addr_i,
    decode_ctrl_if.sink           ctrl,
    id_ex_if.source               bundle
);

    logic [`RV_XLEN-1:0]    imm_i;
    logic [`RV_XLEN-1:0]    imm_u;
    logic [`RV_XLEN-1:0]    imm_s;
    logic [`RV_XLEN-1:0]    imm_b;
    logic [`RV_XLEN-1:0]    imm_j;
    logic [`RV_SHAMT_W-1:0] shamt;

    // everything sign extends from inst[31]
    assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_s = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{(`RV_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};
    assign shamt = inst_i[20 +: `RV_SHAMT_W];

    always_comb begin
        case (ctrl.op1_sel)
            rv64_id_pkg::OP1_RS1: bundle.op1 = rs1_data_i;
            rv64_id_pkg::OP1_PC:  bundle.op1 = inst_addr_i;
            default:              bundle.op1 = '0;
        endcase
        case (ctrl.op2_sel)
            rv64_id_pkg::OP2_RS2:       bundle.op2 = rs2_data_i;
            rv64_id_pkg::OP2_RS2_SHAMT:
                bundle.op2 = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, rs2_data_i[`RV_SHAMT_W-1:0]};
            rv64_id_pkg::OP2_IMM_I:     bundle.op2 = imm_i;
            rv64_id_pkg::OP2_IMM_U:     bundle.op2 = imm_u;
            rv64_id_pkg::OP2_SHAMT:     bundle.op2 = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, shamt};
            rv64_id_pkg::OP2_LINK:      bundle.op2 = `RV_XLEN'(`RV_LINK_OFFSET);
            default:                    bundle.op2 = '0;
        endcase
        case (ctrl.base_sel)
            rv64_id_pkg::BASE_PC:  bundle.base = inst_addr_i;
            rv64_id_pkg::BASE_RS1: bundle.base = rs1_data_i;
            default:               bundle.base = '0;
        endcase
        case (ctrl.offset_sel)
            rv64_id_pkg::OFF_IMM_I: bundle.offset = imm_i;
            rv64_id_pkg::OFF_IMM_S: bundle.offset = imm_s;
            rv64_id_pkg::OFF_IMM_B: bundle.offset = imm_b;
            rv64_id_pkg::OFF_IMM_J: bundle.offset = imm_j;
            rv64_id_pkg::OFF_IMM_U: bundle.offset = imm_u;
            default:                bundle.offset = '0;
        endcase
    end

    // pass-through fields
    assign bundle.valid     = inst_valid_i;
    assign bundle.inst      = inst_i;
    assign bundle.inst_addr = inst_addr_i;
    assign bundle.rd_addr   = rd_addr_i;
    assign bundle.reg_wen   = ctrl.reg_wen;

endmodule

// ==== design/id_ex_reg.sv ====
`include "rv64_id_config.svh"

module id_ex_reg (
    input  logic                  clk,
    input  logic                  reset_i,
    id_ex_if.sink                 bundle,
    output logic                  dec_valid_o,
    output logic [`RV_INST_W-1:0] inst_o,
    output logic [`RV_XLEN-1:0]   inst_addr_o,
    output logic [`RV_XLEN-1:0]   op1_o,
    output logic [`RV_XLEN-1:0]   op2_o,
    output logic [`RV_REG_AW-1:0] rd_addr_o,
    output logic                  reg_wen_o,
    output logic [`RV_XLEN-1:0]   base_addr_o,
    output logic [`RV_XLEN-1:0]   offset_addr_o
);

    // no stall input, the bundle is captured every cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o   <= 1'b0;
            inst_o        <= '0;
            inst_addr_o   <= '0;
            op1_o         <= '0;
            op2_o         <= '0;
            rd_addr_o     <= '0;
            reg_wen_o     <= 1'b0;
            base_addr_o   <= '0;
            offset_addr_o <= '0;
        end else begin
            dec_valid_o   <= bundle.valid; // one pulse per strobe
            inst_o        <= bundle.inst;
            inst_addr_o   <= bundle.inst_addr;
            op1_o         <= bundle.op1;
            op2_o         <= bundle.op2;
            rd_addr_o     <= bundle.rd_addr;
            reg_wen_o     <= bundle.reg_wen;
            base_addr_o   <= bundle.base;
            offset_addr_o <= bundle.offset;
        end
    end

endmodule

// ==== design/rv64_decode_stage.sv ====
`include "rv64_id_config.svh"

module rv64_decode_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    // instruction in
    input  logic                  inst_valid_i,
    input  logic [`RV_INST_W-1:0] inst_i,
    input  logic [`RV_XLEN-1:0]   inst_addr_i,
    // write-back port
    input  logic                  wb_wen_i,
    input  logic [`RV_REG_AW-1:0] wb_addr_i,
    input  logic [`RV_XLEN-1:0]   wb_data_i,
    // to execute
    output logic                  dec_valid_o,
    output logic [`RV_INST_W-1:0] inst_o,
    output logic [`RV_XLEN-1:0]   inst_addr_o,
    output logic [`RV_XLEN-1:0]   op1_o,
    output logic [`RV_XLEN-1:0]   op2_o,
    output logic [`RV_REG_AW-1:0] rd_addr_o,
    output logic                  reg_wen_o,
    output logic [`RV_XLEN-1:0]   base_addr_o,
    output logic [`RV_XLEN-1:0]   offset_addr_o
);

    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    decode_ctrl_if ctrl_if ();
    id_ex_if       ex_if ();

    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (wb_wen_i),
        .waddr_i    (wb_addr_i),
        .wdata_i    (wb_data_i)
    );

    inst_decoder u_inst_decoder (
        .inst_i     (inst_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .ctrl       (ctrl_if.source)
    );

    operand_mux u_operand_mux (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rd_addr_i    (rd_addr),
        .ctrl         (ctrl_if.sink),
        .bundle       (ex_if.source)
    );

    id_ex_reg u_id_ex_reg (
        .clk           (clk),
        .reset_i       (reset_i),
        .bundle        (ex_if.sink),
        .dec_valid_o   (dec_valid_o),
        .inst_o        (inst_o),
        .inst_addr_o   (inst_addr_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .rd_addr_o     (rd_addr_o),
        .reg_wen_o     (reg_wen_o),
        .base_addr_o   (base_addr_o),
        .offset_addr_o (offset_addr_o)
    );

endmodule

// ==== verif/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: name, inst, pc, rd, wen, wb_en, wb_addr, wb_data
// second line of each row: op1, op2, base, offset

// rows before this index see the cleared register file
localparam int PRELOAD_ROW    = 1;
localparam int PRELOAD_CYCLES = 4;

// x2 and x5 negative, x5 and x31 have shift bits above 63
localparam logic [`RV_REG_AW-1:0] PRELOAD_ADDR [PRELOAD_CYCLES] = '{5'd1, 5'd2, 5'd5, 5'd31};
localparam logic [`RV_XLEN-1:0]   PRELOAD_DATA [PRELOAD_CYCLES] =
    '{64'h1000, -64'd16, -64'd145, 64'h47};

task automatic load_table();
    add_vec("addi_pre_load", 32'h00128193, 64'h80000000, 5'd3, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h0, 64'h1, 64'h0, 64'h0);
    add_vec("addi_neg_imm", 32'hff008213, 64'h80000004, 5'd4, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h1000, -64'd16, 64'h0, 64'h0);
    add_vec("slli_shamt", 32'h02d11313, 64'h80000008, 5'd6, 1'b1, 1'b0, 5'd0, 64'h0,
            -64'd16, 64'h2d, 64'h0, 64'h0);
    add_vec("addiw_neg", 32'hffff841b, 64'h8000000c, 5'd8, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h47, -64'd1, 64'h0, 64'h0);
    add_vec("sll_mask", 32'h01f094b3, 64'h80000010, 5'd9, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h1000, 64'h7, 64'h0, 64'h0);
    add_vec("divu_full", 32'h0250d5b3, 64'h80000018, 5'd11, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h1000, -64'd145, 64'h0, 64'h0);
    add_vec("addw", 32'h01f1063b, 64'h8000001c, 5'd12, 1'b1, 1'b0, 5'd0, 64'h0,
            -64'd16, 64'h47, 64'h0, 64'h0);
    add_vec("op32_f3_010", 32'h0020a6bb, 64'h80000020, 5'd0, 1'b0, 1'b0, 5'd0, 64'h0,
            64'h0, 64'h0, 64'h0, 64'h0);
    add_vec("beq_neg", 32'hfe208ce3, 64'h80000024, 5'd0, 1'b0, 1'b0, 5'd0, 64'h0,
            64'h1000, -64'd16, 64'h80000024, -64'd8);
    add_vec("ld_pos", 32'h01813703, 64'h80000028, 5'd14, 1'b1, 1'b0, 5'd0, 64'h0,
            -64'd16, 64'h18, -64'd16, 64'h18);
    add_vec("sd_neg", 32'hfe50be23, 64'h8000002c, 5'd0, 1'b0, 1'b0, 5'd0, 64'h0,
            64'h0, -64'd145, 64'h1000, -64'd4);
    add_vec("jal_neg", 32'hff1ff0ef, 64'h80000030, 5'd1, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h80000030, 64'h4, 64'h80000030, -64'd16);
    add_vec("jalr", 32'h008281e7, 64'h80000034, 5'd3, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h80000034, 64'h4, -64'd145, 64'h8);
    add_vec("lui_neg", 32'h800007b7, 64'h80000038, 5'd15, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h0, 64'hffffffff80000000, 64'h0, 64'h0);
    add_vec("auipc", 32'h12345817, 64'h8000003c, 5'd16, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h8000003c, 64'h12345000, 64'h0, 64'h12345000);
    add_vec("system_ecall", 32'h00000073, 64'h80000040, 5'd0, 1'b0, 1'b0, 5'd0, 64'h0,
            64'h0, 64'h0, 64'h0, 64'h0);
    add_vec("opcode_zero", 32'h12345600, 64'h80000044, 5'd0, 1'b0, 1'b0, 5'd0, 64'h0,
            64'h0, 64'h0, 64'h0, 64'h0);
    add_vec("load_f3_111", 32'h01817703, 64'h80000048, 5'd0, 1'b0, 1'b0, 5'd0, 64'h0,
            64'h0, 64'h0, 64'h0, 64'h0);
    add_vec("wb_x0", 32'h00500893, 64'h8000004c, 5'd17, 1'b1, 1'b1, 5'd0, 64'hdeadbeef,
            64'h0, 64'h5, 64'h0, 64'h0);
    // x1 written in the strobe cycle, old value expected
    add_vec("wb_same_cycle", 32'h000089b3, 64'h80000050, 5'd19, 1'b1, 1'b1, 5'd1, 64'h2222,
            64'h1000, 64'h0, 64'h0, 64'h0);
    add_vec("wb_seen_next", 32'h00008a13, 64'h80000054, 5'd20, 1'b1, 1'b0, 5'd0, 64'h0,
            64'h2222, 64'h0, 64'h0, 64'h0);
endtask

`endif

// ==== verif/tb_decode_stage.sv ====
`include "rv64_id_config.svh"

module tb_decode_stage;

    typedef struct packed {
        logic [`RV_INST_W-1:0] inst;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  wen;
        logic                  wb_en; // write-back alongside the strobe
        logic [`RV_REG_AW-1:0] wb_addr;
        logic [`RV_XLEN-1:0]   wb_data;
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        logic [`RV_XLEN-1:0]   base;
        logic [`RV_XLEN-1:0]   offset;
    } vec_t;

    logic                  clk = 1'b0;
    logic                  reset_i = 1'b1;
    logic                  inst_valid_i = 1'b0;
    logic [`RV_INST_W-1:0] inst_i = '0;
    logic [`RV_XLEN-1:0]   inst_addr_i = '0;
    logic                  wb_wen_i = 1'b0;
    logic [`RV_REG_AW-1:0] wb_addr_i = '0;
    logic [`RV_XLEN-1:0]   wb_data_i = '0;
    logic                  dec_valid_o;
    logic [`RV_INST_W-1:0] inst_o;
    logic [`RV_XLEN-1:0]   inst_addr_o;
    logic [`RV_XLEN-1:0]   op1_o;
    logic [`RV_XLEN-1:0]   op2_o;
    logic [`RV_REG_AW-1:0] rd_addr_o;
    logic                  reg_wen_o;
    logic [`RV_XLEN-1:0]   base_addr_o;
    logic [`RV_XLEN-1:0]   offset_addr_o;

    vec_t  vecs [$];
    string vec_name [$];
    int    pass_count = 0;
    int    fail_count = 0;
    int    err_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000; // replaced once the table is loaded

    rv64_decode_stage u_rv64_decode_stage (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .wb_wen_i      (wb_wen_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .dec_valid_o   (dec_valid_o),
        .inst_o        (inst_o),
        .inst_addr_o   (inst_addr_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .rd_addr_o     (rd_addr_o),
        .reg_wen_o     (reg_wen_o),
        .base_addr_o   (base_addr_o),
        .offset_addr_o (offset_addr_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic add_vec(input string name, input logic [`RV_INST_W-1:0] inst,
                           input logic [`RV_XLEN-1:0] pc, input logic [`RV_REG_AW-1:0] rd,
                           input logic wen, input logic wb_en,
                           input logic [`RV_REG_AW-1:0] wb_addr,
                           input logic [`RV_XLEN-1:0] wb_data,
                           input logic [`RV_XLEN-1:0] op1, input logic [`RV_XLEN-1:0] op2,
                           input logic [`RV_XLEN-1:0] base,
                           input logic [`RV_XLEN-1:0] offset);
        vec_t v;
        v = '{inst, pc, rd, wen, wb_en, wb_addr, wb_data, op1, op2, base, offset};
        vecs.push_back(v);
        vec_name.push_back(name);
    endtask

`include "tb_vectors.svh"

    task automatic check_val(input string test, input string field,
                             input logic [63:0] exp_val, input logic [63:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Error %s %s: expected %h, actual %h", test, field, exp_val, act_val);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: fail", name);
        end
    endtask

    // write-back port only, no strobe
    task automatic preload_regs();
        inst_valid_i = 1'b0;
        for (int k = 0; k < PRELOAD_CYCLES; k++) begin
            wb_wen_i  = 1'b1;
            wb_addr_i = PRELOAD_ADDR[k];
            wb_data_i = PRELOAD_DATA[k];
            @(negedge clk);
        end
        wb_wen_i = 1'b0;
    endtask

    task automatic drive_row(input int idx);
        vec_t v;
        v = vecs[idx];
        inst_valid_i = 1'b1;
        inst_i       = v.inst;
        inst_addr_i  = v.pc;
        wb_wen_i     = v.wb_en;
        wb_addr_i    = v.wb_addr;
        wb_data_i    = v.wb_data;
    endtask

    task automatic check_row(input int idx);
        vec_t  v;
        string name;
        int    errs_at_start;
        v = vecs[idx];
        name = vec_name[idx];
        errs_at_start = err_count;
        check_val(name, "valid", 64'(1), 64'(dec_valid_o));
        check_val(name, "inst", 64'(v.inst), 64'(inst_o)); // passes through even if illegal
        check_val(name, "pc", v.pc, inst_addr_o);
        check_val(name, "op1", v.op1, op1_o);
        check_val(name, "op2", v.op2, op2_o);
        check_val(name, "rd", 64'(v.rd), 64'(rd_addr_o));
        check_val(name, "wen", 64'(v.wen), 64'(reg_wen_o));
        check_val(name, "base", v.base, base_addr_o);
        check_val(name, "offset", v.offset, offset_addr_o);
        finish_test(name, errs_at_start);
    endtask

    initial begin
        int errs_at_start;
        load_table();
        cycle_limit = 2 + PRELOAD_CYCLES + 2 * vecs.size() + 20;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        errs_at_start = err_count;
        check_val("reset_state", "valid", 64'(0), 64'(dec_valid_o));
        check_val("reset_state", "wen", 64'(0), 64'(reg_wen_o));
        check_val("reset_state", "op1", 64'(0), op1_o);
        finish_test("reset_state", errs_at_start);
        // each row checked on the falling edge after its strobe, next row driven right away
        for (int i = 0; i < vecs.size(); i++) begin
            if (i == PRELOAD_ROW) begin
                preload_regs();
            end
            drive_row(i);
            @(negedge clk);
            check_row(i);
        end
        inst_valid_i = 1'b0;
        wb_wen_i     = 1'b0;
        @(negedge clk);
        errs_at_start = err_count;
        check_val("pulse_end", "valid", 64'(0), 64'(dec_valid_o)); // last pulse one cycle wide
        finish_test("pulse_end", errs_at_start);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
+incdir+verif
design/rv64_id_pkg.sv
design/decode_if.sv
design/reg_file.sv
design/inst_decoder.sv
design/operand_mux.sv
design/id_ex_reg.sv
design/rv64_decode_stage.sv
verif/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
